//--- source/bridge_pkg.sv
package bridge_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [2:0] bus_addr_t;
    typedef logic [1:0] param_idx_t;
    typedef logic [4:0] cmd_idx_t;

    localparam int CLKS_PER_BIT    = 8;
    localparam int MAX_CMD_LENGTH  = 30;
    localparam int CMD_WORD_LENGTH = 11;   // Includes the trailing comma
    localparam int NUM_PARAMS      = 4;

    typedef logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt_t;

    localparam logic [8*CMD_WORD_LENGTH-1:0] CMD_WRITE = "pb_i_write,";
    localparam logic [8*CMD_WORD_LENGTH-1:0] CMD_READ  = "pb_i__read,";

    localparam byte_t CHAR_CR    = 8'h0D;
    localparam byte_t CHAR_LF    = 8'h0A;
    localparam byte_t CHAR_COMMA = 8'h2C;

    localparam int          FAIL_TEXT_LEN = 9;
    localparam logic [71:0] FAIL_TEXT     = "Failed 0x";
    localparam logic [15:0] OK_TEXT       = "OK";
    localparam byte_t       FAIL_CODE     = 8'hFE;

    typedef enum logic [1:0] {
        cmd_write,
        cmd_read,
        cmd_bad
    } cmd_kind_t;

    typedef enum logic [1:0] {
        bus_idle,
        bus_setup,
        bus_strobe,
        bus_hold
    } bus_state_t;

    typedef enum logic [1:0] {
        reply_idle,
        reply_load,
        reply_send,
        reply_wait
    } reply_state_t;

    // ASCII hex digit to nibble, anything else gives 0
    function automatic logic [3:0] hex_to_nibble(input byte_t c);
        if (c >= "0" && c <= "9") return 4'(c - "0");
        if (c >= "A" && c <= "F") return 4'(c - "A" + 8'd10);
        if (c >= "a" && c <= "f") return 4'(c - "a" + 8'd10);
        return 4'h0;
    endfunction

    function automatic byte_t nibble_to_hex(input logic [3:0] n);
        return (n < 4'd10) ? ("0" + byte_t'(n)) : ("A" + byte_t'(n) - 8'd10);
    endfunction

endpackage

//--- source/uart_rx.sv
module uart_rx (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              rx_pin,
    output bridge_pkg::byte_t rx_byte,
    output logic              rx_valid
);
    import bridge_pkg::*;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t  state;
    logic [1:0] rx_sync;   // Two-flop synchronizer
    logic       rx_line;
    baud_cnt_t  baud_cnt;
    logic [2:0] bit_cnt;
    logic       bit_end;

    assign rx_line  = rx_sync[1];
    assign bit_end  = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));
    assign rx_valid = (state == rx_stop) && bit_end && rx_line;   // Good stop bit only

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rx_sync  <= 2'b11;
            state    <= rx_idle;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            rx_sync <= {rx_sync[0], rx_pin};
            case (state)
                rx_idle: begin
                    baud_cnt <= '0;
                    if (!rx_line) state <= rx_start;
                end
                rx_start: begin
                    if (baud_cnt == baud_cnt_t'(CLKS_PER_BIT / 2 - 1)) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_line ? rx_idle : rx_data;   // Glitch check at mid bit
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    baud_cnt <= baud_cnt + 1'b1;
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= rx_stop;
                    end
                end
                rx_stop: begin
                    baud_cnt <= baud_cnt + 1'b1;
                    if (bit_end) state <= rx_idle;
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clock) begin
        if (state == rx_data && bit_end) rx_byte <= {rx_line, rx_byte[7:1]};
    end

    assert property (@(posedge clock) disable iff (!arst_n) rx_valid |=> !rx_valid)
        else $error("rx_valid held for more than one cycle");

endmodule

//--- source/uart_tx.sv
module uart_tx (
    input  logic              clock,
    input  logic              arst_n,
    input  bridge_pkg::byte_t tx_byte,
    input  logic              tx_load,
    output logic              tx_pin,
    output logic              tx_busy
);
    import bridge_pkg::*;

    logic [9:0] frame;      // Stop, data and start bit, shifted out LSB first
    baud_cnt_t  baud_cnt;
    logic [3:0] bit_cnt;

    assign tx_pin = frame[0];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            frame    <= '1;   // Line idles high
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx_busy  <= 1'b0;
        end else if (tx_load && !tx_busy) begin
            frame    <= {1'b1, tx_byte, 1'b0};
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx_busy  <= 1'b1;
        end else if (tx_busy) begin
            if (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1)) begin
                baud_cnt <= '0;
                frame    <= {1'b1, frame[9:1]};
                if (bit_cnt == 4'd9) begin
                    tx_busy <= 1'b0;   // Stop bit done
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    // The reply builder must see tx_busy low before it loads
    assert property (@(posedge clock) disable iff (!arst_n) tx_load |-> !tx_busy)
        else $error("tx_load while transmitter busy");

endmodule

//--- source/command_parser.sv
module command_parser (
    input  logic                  clock,
    input  logic                  arst_n,
    input  bridge_pkg::byte_t     rx_byte,
    input  logic                  rx_valid,
    input  logic                  cmd_done,
    output logic                  cmd_start,
    output bridge_pkg::cmd_kind_t cmd_kind,
    output bridge_pkg::byte_t     params [bridge_pkg::NUM_PARAMS]
);
    import bridge_pkg::*;

    byte_t    cmd_buf [MAX_CMD_LENGTH];
    cmd_idx_t wr_idx;        // Characters stored so far
    cmd_idx_t comma_pos;
    cmd_idx_t comma_next;
    logic     comma_found;
    logic     comma_hit;
    logic     find_q;        // Comma search cycle
    logic     waiting;       // Command in flight, input dropped
    logic     take_byte;
    logic [8*CMD_WORD_LENGTH-1:0] cmd_word;

    assign take_byte = rx_valid && !waiting && rx_byte != CHAR_CR && rx_byte != CHAR_LF
                       && wr_idx < cmd_idx_t'(MAX_CMD_LENGTH);

    // First comma wins, so scan from the top down
    always_comb begin
        comma_hit  = 1'b0;
        comma_next = '0;
        for (int i = MAX_CMD_LENGTH - 1; i >= 0; i--) begin
            if (cmd_idx_t'(i) < wr_idx && cmd_buf[i] == CHAR_COMMA) begin
                comma_hit  = 1'b1;
                comma_next = cmd_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_idx      <= '0;
            comma_pos   <= '0;
            comma_found <= 1'b0;
            find_q      <= 1'b0;
            cmd_start   <= 1'b0;
            waiting     <= 1'b0;
        end else begin
            find_q    <= rx_valid && !waiting && rx_byte == CHAR_LF;
            cmd_start <= find_q;   // Decode is valid in this cycle
            if (find_q) begin
                comma_pos   <= comma_next;
                comma_found <= comma_hit;
            end
            if (cmd_done) begin
                waiting <= 1'b0;
                wr_idx  <= '0;
            end else if (rx_valid && !waiting && rx_byte == CHAR_LF) begin
                waiting <= 1'b1;
            end else if (take_byte) begin
                wr_idx <= wr_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take_byte) cmd_buf[wr_idx] <= rx_byte;
    end

    always_comb begin
        for (int i = 0; i < CMD_WORD_LENGTH; i++) begin
            cmd_word[8*(CMD_WORD_LENGTH-1-i) +: 8] = cmd_buf[i];
        end
    end

    always_comb begin
        cmd_kind = cmd_bad;
        if (comma_found && comma_pos == cmd_idx_t'(CMD_WORD_LENGTH - 1)) begin
            if (cmd_word == CMD_WRITE) begin
                cmd_kind = cmd_write;
            end else if (cmd_word == CMD_READ) begin
                cmd_kind = cmd_read;
            end
        end
    end

    // Two hex digits per byte after the comma, missing digits give 0
    always_comb begin
        int pos;
        for (int k = 0; k < NUM_PARAMS; k++) begin
            pos       = int'(comma_pos) + 1 + 2 * k;
            params[k] = '0;
            if (pos + 1 < int'(wr_idx)) begin
                params[k] = {hex_to_nibble(cmd_buf[pos]), hex_to_nibble(cmd_buf[pos + 1])};
            end
        end
    end

endmodule

//--- source/bus_sequencer.sv
module bus_sequencer (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   cmd_start,
    input  bridge_pkg::cmd_kind_t  cmd_kind,
    input  bridge_pkg::byte_t      params [bridge_pkg::NUM_PARAMS],
    inout  wire bridge_pkg::byte_t data_port,
    output bridge_pkg::bus_addr_t  bus_addr,
    output logic                   bus_rd,
    output logic                   bus_wr,
    output bridge_pkg::byte_t      read_data [bridge_pkg::NUM_PARAMS],
    output logic                   seq_done
);
    import bridge_pkg::*;

    bus_state_t state;
    param_idx_t cycle_idx;   // Also the bus address
    logic       is_read;
    logic       data_dir;    // Bridge drives data_port

    assign bus_addr  = bus_addr_t'(cycle_idx);
    assign data_port = data_dir ? params[cycle_idx] : 'z;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state     <= bus_idle;
            cycle_idx <= '0;
            is_read   <= 1'b0;
            data_dir  <= 1'b0;
            bus_rd    <= 1'b0;
            bus_wr    <= 1'b0;
            seq_done  <= 1'b0;
        end else begin
            seq_done <= 1'b0;
            case (state)
                bus_idle: begin
                    if (cmd_start && cmd_kind != cmd_bad) begin
                        state     <= bus_setup;
                        cycle_idx <= '0;
                        is_read   <= (cmd_kind == cmd_read);
                        data_dir  <= (cmd_kind == cmd_write);
                    end
                end
                bus_setup: begin
                    state  <= bus_strobe;
                    bus_wr <= !is_read;
                    bus_rd <= is_read;
                end
                bus_strobe: begin
                    state    <= bus_hold;
                    bus_wr   <= 1'b0;
                    seq_done <= (cycle_idx == param_idx_t'(NUM_PARAMS - 1));   // Lands in last hold
                end
                bus_hold: begin
                    bus_rd <= 1'b0;
                    if (cycle_idx == param_idx_t'(NUM_PARAMS - 1)) begin
                        state     <= bus_idle;
                        cycle_idx <= '0;
                        data_dir  <= 1'b0;
                    end else begin
                        state     <= bus_setup;
                        cycle_idx <= cycle_idx + 1'b1;
                    end
                end
            endcase
        end
    end

    // Sampled at the end of the hold cycle
    always_ff @(posedge clock) begin
        if (state == bus_hold && is_read) read_data[cycle_idx] <= data_port;
    end

    assert property (@(posedge clock) disable iff (!arst_n) !(bus_rd && bus_wr))
        else $error("bus_rd and bus_wr high together");

    assert property (@(posedge clock) disable iff (!arst_n) !(bus_rd && data_dir))
        else $error("Read strobe while the bridge drives data_port");

endmodule

//--- source/reply_builder.sv
module reply_builder (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  cmd_start,
    input  bridge_pkg::cmd_kind_t cmd_kind,
    input  logic                  seq_done,
    input  bridge_pkg::byte_t     read_data [bridge_pkg::NUM_PARAMS],
    input  logic                  tx_busy,
    output bridge_pkg::byte_t     tx_byte,
    output logic                  tx_load,
    output logic                  cmd_done
);
    import bridge_pkg::*;

    reply_state_t state;
    cmd_kind_t    kind_q;
    logic [4:0]   char_idx;
    logic [4:0]   last_idx;
    byte_t        cur_char;

    always_comb begin
        case (kind_q)
            cmd_bad:   last_idx = 5'(FAIL_TEXT_LEN + 3);
            cmd_write: last_idx = 5'(CMD_WORD_LENGTH + 3);
            default:   last_idx = 5'(CMD_WORD_LENGTH + 2 * NUM_PARAMS + 1);
        endcase
    end

    // Character at char_idx, LF closes every reply
    always_comb begin
        int    pos;
        int    rel;
        byte_t src;
        pos      = int'(char_idx);
        rel      = 0;
        src      = FAIL_CODE;
        cur_char = CHAR_LF;
        if (kind_q == cmd_bad) begin
            rel = pos - FAIL_TEXT_LEN;
            if (pos < FAIL_TEXT_LEN) begin
                cur_char = FAIL_TEXT[8*(FAIL_TEXT_LEN-1-pos) +: 8];
            end else if (rel < 2) begin
                cur_char = nibble_to_hex(rel[0] ? src[3:0] : src[7:4]);
            end else if (rel == 2) begin
                cur_char = CHAR_CR;
            end
        end else if (pos < CMD_WORD_LENGTH) begin
            cur_char = (kind_q == cmd_write) ? CMD_WRITE[8*(CMD_WORD_LENGTH-1-pos) +: 8]
                                             : CMD_READ[8*(CMD_WORD_LENGTH-1-pos) +: 8];
        end else begin
            rel = pos - CMD_WORD_LENGTH;
            if (kind_q == cmd_write) begin
                if (rel < 2) cur_char = OK_TEXT[8*(1-rel) +: 8];
                else if (rel == 2) cur_char = CHAR_CR;
            end else if (rel < 2 * NUM_PARAMS) begin
                src      = read_data[rel / 2];   // Byte 0 first, high nibble first
                cur_char = nibble_to_hex(rel[0] ? src[3:0] : src[7:4]);
            end else if (rel == 2 * NUM_PARAMS) begin
                cur_char = CHAR_CR;
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state    <= reply_idle;
            kind_q   <= cmd_bad;
            char_idx <= '0;
            tx_load  <= 1'b0;
            cmd_done <= 1'b0;
        end else begin
            tx_load  <= 1'b0;
            cmd_done <= 1'b0;
            case (state)
                reply_idle: begin
                    if (seq_done || (cmd_start && cmd_kind == cmd_bad)) begin
                        kind_q   <= cmd_kind;
                        char_idx <= '0;
                        state    <= reply_load;
                    end
                end
                reply_load: begin
                    if (!tx_busy) begin
                        tx_load <= 1'b1;
                        state   <= reply_send;
                    end
                end
                reply_send: begin   // tx_busy not yet up in this cycle
                    if (char_idx == last_idx) begin
                        cmd_done <= 1'b1;
                        state    <= reply_idle;
                    end else begin
                        char_idx <= char_idx + 1'b1;
                        state    <= reply_wait;
                    end
                end
                reply_wait: begin
                    if (!tx_busy) state <= reply_load;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == reply_load && !tx_busy) tx_byte <= cur_char;
    end

endmodule

//--- source/bus_bridge_top.sv
module bus_bridge_top (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   uart_rx_pin,
    output logic                   uart_tx_pin,
    inout  wire bridge_pkg::byte_t data_port,
    output bridge_pkg::bus_addr_t  bus_addr,
    output logic                   bus_rd,
    output logic                   bus_wr
);
    import bridge_pkg::*;

    byte_t     rx_byte;
    logic      rx_valid;
    logic      cmd_start;
    logic      cmd_done;
    cmd_kind_t cmd_kind;
    byte_t     params [NUM_PARAMS];
    byte_t     read_data [NUM_PARAMS];
    logic      seq_done;
    byte_t     tx_byte;
    logic      tx_load;
    logic      tx_busy;

    uart_rx u_uart_rx (
        .clock(clock), .arst_n(arst_n), .rx_pin(uart_rx_pin),
        .rx_byte(rx_byte), .rx_valid(rx_valid)
    );

    command_parser u_command_parser (
        .clock(clock), .arst_n(arst_n), .rx_byte(rx_byte), .rx_valid(rx_valid),
        .cmd_done(cmd_done), .cmd_start(cmd_start), .cmd_kind(cmd_kind), .params(params)
    );

    bus_sequencer u_bus_sequencer (
        .clock(clock), .arst_n(arst_n), .cmd_start(cmd_start), .cmd_kind(cmd_kind),
        .params(params), .data_port(data_port), .bus_addr(bus_addr), .bus_rd(bus_rd),
        .bus_wr(bus_wr), .read_data(read_data), .seq_done(seq_done)
    );

    reply_builder u_reply_builder (
        .clock(clock), .arst_n(arst_n), .cmd_start(cmd_start), .cmd_kind(cmd_kind),
        .seq_done(seq_done), .read_data(read_data), .tx_busy(tx_busy),
        .tx_byte(tx_byte), .tx_load(tx_load), .cmd_done(cmd_done)
    );

    uart_tx u_uart_tx (
        .clock(clock), .arst_n(arst_n), .tx_byte(tx_byte), .tx_load(tx_load),
        .tx_pin(uart_tx_pin), .tx_busy(tx_busy)
    );

endmodule

//--- tb/tb_clock_gen.sv
module tb_clock_gen (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock  = 1'b0;
        arst_n = 1'b0;
        repeat (16) @(posedge clock);   // Reset held for 16 cycles
        arst_n <= 1'b1;
    end

    always #50 clock = ~clock;   // Period 100

endmodule

//--- tb/bus_bridge_tb.sv
module bus_bridge_tb;
    import bridge_pkg::*;

    localparam int WATCHDOG_CYCLES = 5 * 40 * 10 * CLKS_PER_BIT * 2;

    logic       clock;
    logic       arst_n;
    logic       uart_rx_pin;
    logic       uart_tx_pin;
    wire byte_t data_port;
    bus_addr_t  bus_addr;
    logic       bus_rd;
    logic       bus_wr;

    byte_t regs [NUM_PARAMS];       // Bus register model
    byte_t mirror [NUM_PARAMS];     // Contents the registers should hold
    byte_t exp_bytes [NUM_PARAMS];  // Write data of the running command
    byte_t exp_q [$];               // Reply characters still to come
    byte_t exp_wdata;
    byte_t got_char;
    byte_t want_char;
    logic  char_seen = 1'b0;
    logic  char_extra;
    logic  stop_ok;
    logic  wr_allowed = 1'b0;
    logic  rd_allowed = 1'b0;
    logic  strobe_start;
    int    strobe_idx;
    int    strobe_total = 0;
    int    strobe_base = 0;
    int    rd_run = 0;              // Consecutive cycles with bus_rd high
    int    cycle_cnt = 0;
    int    rx_count = 0;
    int    exp_total = 0;
    int    cmd_count = 0;
    int    errors = 0;
    string test_name = "reset";

    tb_clock_gen u_clock_gen (.clock(clock), .arst_n(arst_n));

    bus_bridge_top u_dut (
        .clock(clock), .arst_n(arst_n), .uart_rx_pin(uart_rx_pin), .uart_tx_pin(uart_tx_pin),
        .data_port(data_port), .bus_addr(bus_addr), .bus_rd(bus_rd), .bus_wr(bus_wr)
    );

    assign data_port    = bus_rd ? regs[bus_addr[1:0]] : 'z;   // Model answers reads only
    assign strobe_start = bus_wr || (bus_rd && rd_run == 0);
    assign strobe_idx   = strobe_total - strobe_base;
    assign exp_wdata    = exp_bytes[strobe_idx[1:0]];

    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
        rd_run    <= bus_rd ? rd_run + 1 : 0;
        if (strobe_start) strobe_total <= strobe_total + 1;
        if (bus_wr) regs[bus_addr[1:0]] <= data_port;
    end

    function automatic void log_error(input string msg);
        errors++;
        $display("%s", msg);
    endfunction

    function automatic byte_t ascii_hex(input logic [3:0] n, input bit upper);
        if (n < 4'd10) return 8'h30 + 8'(n);
        return (upper ? 8'h41 : 8'h61) + 8'(n) - 8'd10;
    endfunction

    assert property (@(posedge clock) (cycle_cnt >= 2 && cycle_cnt <= 20) |->
            uart_tx_pin && !bus_rd && !bus_wr && !u_dut.u_bus_sequencer.data_dir)
        else log_error("Outputs not idle during or just after reset");
    assert property (@(posedge clock) char_seen |-> stop_ok && !char_extra)
        else log_error($sformatf("In %s the reply has a bad stop bit or too many characters",
                                 test_name));
    assert property (@(posedge clock) char_seen |-> got_char == want_char)
        else log_error($sformatf("[ERROR] %s: reply char expected 0x%02h, actual 0x%02h",
                                 test_name, want_char, got_char));
    assert property (@(posedge clock) disable iff (!arst_n)
            !(bus_wr && !wr_allowed) && !(bus_rd && !rd_allowed))
        else log_error($sformatf("In %s a bus strobe came that the command does not allow",
                                 test_name));
    assert property (@(posedge clock) disable iff (!arst_n)
            strobe_start |-> int'(bus_addr) == strobe_idx)
        else log_error($sformatf("[ERROR] %s: bus_addr expected %0d, actual %0d",
                                 test_name, $sampled(strobe_idx), $sampled(bus_addr)));
    assert property (@(posedge clock) disable iff (!arst_n) bus_wr |-> data_port == exp_wdata)
        else log_error($sformatf("[ERROR] %s: write data expected 0x%02h, actual 0x%02h",
                                 test_name, $sampled(exp_wdata), $sampled(data_port)));
    // Setup, strobe and hold share address and data
    assert property (@(posedge clock) disable iff (!arst_n)
            (bus_wr || $fell(bus_wr)) |-> $stable(bus_addr) && $stable(data_port))
        else log_error("Write cycle does not hold address and data for three cycles");
    assert property (@(posedge clock) disable iff (!arst_n) bus_wr |=> !bus_wr)
        else log_error("bus_wr strobe lasted more than one cycle");
    assert property (@(posedge clock) disable iff (!arst_n)
            bus_rd |-> $stable(bus_addr) && rd_run < 2)
        else log_error("Read strobe too long or address moved during the read cycle");
    assert property (@(posedge clock) disable iff (!arst_n) $fell(bus_rd) |-> rd_run == 2)
        else log_error("Read strobe shorter than strobe plus hold");

    // Host side receiver, sampled mid bit on the falling edge
    initial begin : tx_decode
        byte_t c;
        forever begin
            @(negedge clock);
            if (arst_n && !uart_tx_pin) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clock);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clock);
                    c[i] = uart_tx_pin;
                end
                repeat (CLKS_PER_BIT) @(negedge clock);
                stop_ok    = uart_tx_pin;
                got_char   = c;
                char_extra = (exp_q.size() == 0);
                want_char  = char_extra ? c : exp_q.pop_front();
                char_seen  = 1'b1;
                @(negedge clock);
                char_seen = 1'b0;
                rx_count++;
            end
        end
    end

    task automatic send_char(input byte_t c);
        logic [9:0] frame;
        frame = {1'b1, c, 1'b0};   // Stop, data, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clock);
            uart_rx_pin <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clock);
        end
    endtask

    task automatic send_text(input string s);
        for (int i = 0; i < s.len(); i++) send_char(s[i]);
    endtask

    task automatic expect_char(input byte_t c);
        exp_q.push_back(c);
        exp_total++;
    endtask

    task automatic expect_text(input string s);
        for (int i = 0; i < s.len(); i++) expect_char(s[i]);
        expect_char(CHAR_CR);
        expect_char(CHAR_LF);
    endtask

    task automatic start_cmd(input string name, input logic wr, input logic rd);
        @(posedge clock);
        test_name   = name;
        wr_allowed  = wr;
        rd_allowed  = rd;
        strobe_base = strobe_total;
        cmd_count++;
    endtask

    task automatic end_cmd(input int strobes);
        wait (rx_count == exp_total);   // Watchdog covers a missing reply
        @(posedge clock);
        assert (strobe_total - strobe_base == strobes)
        else log_error($sformatf("[ERROR] %s: bus strobes expected %0d, actual %0d",
                                 test_name, strobes, strobe_total - strobe_base));
        wr_allowed = 1'b0;
        rd_allowed = 1'b0;
    endtask

    task automatic write_cmd(input string name, input byte_t data [NUM_PARAMS],
                             input bit upper, input bit with_cr);
        start_cmd(name, 1'b1, 1'b0);
        exp_bytes = data;
        expect_text("pb_i_write,OK");
        send_text("pb_i_write,");
        for (int k = 0; k < NUM_PARAMS; k++) begin
            send_char(ascii_hex(data[k][7:4], upper));
            send_char(ascii_hex(data[k][3:0], upper));
        end
        if (with_cr) send_char(CHAR_CR);
        send_char(CHAR_LF);
        end_cmd(NUM_PARAMS);
        mirror = data;
    endtask

    task automatic read_cmd(input string name);
        string txt;
        start_cmd(name, 1'b0, 1'b1);
        txt = "pb_i__read,";
        for (int k = 0; k < NUM_PARAMS; k++) begin
            txt = {txt, string'(ascii_hex(mirror[k][7:4], 1'b1))};
            txt = {txt, string'(ascii_hex(mirror[k][3:0], 1'b1))};
        end
        expect_text(txt);
        send_text("pb_i__read,");
        send_char(CHAR_LF);
        end_cmd(NUM_PARAMS);
    endtask

    task automatic bad_cmd(input string name, input string line);
        start_cmd(name, 1'b0, 1'b0);
        expect_text("Failed 0xFE");
        send_text(line);
        send_char(CHAR_LF);
        end_cmd(0);
    endtask

    initial begin : stimulus
        byte_t data [NUM_PARAMS];
        void'($urandom(90186));
        uart_rx_pin = 1'b1;
        for (int i = 0; i < NUM_PARAMS; i++) begin
            regs[i]   = 8'h5A ^ 8'(i * 8'h37);
            mirror[i] = regs[i];
        end
        wait (arst_n);
        repeat (8) @(posedge clock);
        read_cmd("read_initial");
        data = '{8'h12, 8'h34, 8'hAB, 8'hCD};
        write_cmd("write_upper", data, 1'b1, 1'b0);
        for (int i = 0; i < NUM_PARAMS; i++) data[i] = 8'($urandom);
        write_cmd("write_lower_cr", data, 1'b0, 1'b1);
        read_cmd("read_random");
        bad_cmd("bad_word", "pb_i_wrote,12345678");
        read_cmd("read_after_bad");
        $display("Summary: %0d commands, %0d reply characters, %0d errors",
                 cmd_count, rx_count, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        errors++;
        $display("Timeout after %0d clock cycles, the DUT stopped answering", WATCHDOG_CYCLES);
        $display("Summary: %0d commands, %0d reply characters, %0d errors",
                 cmd_count, rx_count, errors);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- list.f
source/bridge_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/command_parser.sv
source/bus_sequencer.sv
source/reply_builder.sv
source/bus_bridge_top.sv
tb/tb_clock_gen.sv
tb/bus_bridge_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module bus_bridge_tb -f list.f
	./obj_dir/Vbus_bridge_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG) || ! grep -q "PASS: all tests" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
